// File: rv32v_decode_stage.f
+incdir+hw
hw/vdec_pkg.sv
hw/vector_control_unit.sv
hw/element_counter.sv
hw/operand_offset_gen.sv
hw/uop_pipe_reg.sv
hw/rv32v_decode_stage.sv
verification/tb_rv32v_decode_stage.sv

// File: Bender.yml
package:
  name: rv32v_decode_stage

sources:
  - include_dirs:
      - hw
    files:
      - hw/vdec_pkg.sv
      - hw/vector_control_unit.sv
      - hw/element_counter.sv
      - hw/operand_offset_gen.sv
      - hw/uop_pipe_reg.sv
      - hw/rv32v_decode_stage.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/tb_rv32v_decode_stage.sv

// File: verification/tb_rv32v_decode_stage.sv
/* decode stage testbench
   table-driven checks of the micro-op stream against a reference model */
`timescale 1ns/10ps
`default_nettype none

`include "vdec_consts.svh"

module tb_rv32v_decode_stage;
  import vdec_pkg::*;

  localparam int N_TESTS = 19;

  // one table row per instruction
  // flush_after counts micro-ops taken before a flush or is zero for none
  typedef struct packed {
    logic [31:0] instr;
    vop_t        op;
    logic [7:0]  vl;
    logic [7:0]  vstart;
    sew_t        sew;
    logic [31:0] xs1;
    logic [15:0] mask;
    logic        stall;
    logic [7:0]  flush_after;
  } test_t;

  logic              CLK;
  logic              nRST;
  logic              flush;
  logic              in_valid;
  logic              in_ready;
  logic [31:0]       instr;
  vcsr_t             csr;
  logic [31:0]       xs1;
  logic [`VLENB-1:0] v0_mask;
  logic              out_valid;
  logic              out_ready;
  uop_t              uop;

  test_t  tests [N_TESTS];
  uop_t   exp_q [$];
  integer seed;
  int     errors;
  int     cycles;
  int     limit;

  rv32v_decode_stage DUT (
    .CLK       (CLK),
    .nRST      (nRST),
    .flush     (flush),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .instr     (instr),
    .csr       (csr),
    .xs1       (xs1),
    .v0_mask   (v0_mask),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .uop       (uop)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (limit != 0 && cycles >= limit) begin
      $display("timeout after %0d cycles, the micro-op stream did not finish", cycles);
      $display("TESTS FAILED");
      $fatal(1, "timeout");
    end
  end

  // OP-V encoding with the vm bit and register fields
  function automatic logic [31:0] enc(input logic [5:0] f6, input logic vm,
                                      input logic [4:0] vs2, input logic [4:0] vs1,
                                      input logic [2:0] f3, input logic [4:0] vd);
    return {f6, vm, vs2, vs1, f3, vd, 7'b1010111};
  endfunction

  function automatic test_t row(input logic [31:0] ins, input vop_t op, input logic [7:0] vl,
                                input logic [7:0] vstart, input sew_t sew,
                                input logic [31:0] x, input logic [15:0] mask,
                                input logic stall, input logic [7:0] flush_after);
    return '{ins, op, vl, vstart, sew, x, mask, stall, flush_after};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors = errors + 1;
      $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "check failed");
    end
  endtask

  task automatic check_uop(input uop_t got, input uop_t exp);
    check_value("uop.op", got.op, exp.op);
    check_value("uop.vd", got.vd, exp.vd);
    check_value("uop.vs1", got.vs1, exp.vs1);
    check_value("uop.vs2", got.vs2, exp.vs2);
    check_value("uop.eew", got.eew, exp.eew);
    check_value("uop.vs2_off0", got.vs2_off0, exp.vs2_off0);
    check_value("uop.vs2_off1", got.vs2_off1, exp.vs2_off1);
    check_value("uop.wd_off0", got.wd_off0, exp.wd_off0);
    check_value("uop.wd_off1", got.wd_off1, exp.wd_off1);
    check_value("uop.wen", got.wen, exp.wen);
    check_value("uop.imm", got.imm, exp.imm);
    check_value("uop.xs1", got.xs1, exp.xs1);
    check_value("uop.last", got.last, exp.last);
  endtask

  // reference model, one entry per expected micro-op
  task automatic build_expected(input test_t t);
    uop_t       u;
    logic [7:0] base;
    logic [7:0] idx_add;
    logic [4:0] imm5;
    int         idx;
    exp_q.delete();
    imm5 = t.instr[19:15];
    // scalar form adds rs1, immediate form adds the zero-extended uimm
    idx_add = (t.instr[14:12] == 3'b100) ? t.xs1[7:0] : {3'b000, imm5};
    base = t.vstart;
    do begin
      u.op  = t.op;
      u.vd  = t.instr[11:7];
      u.vs1 = t.instr[19:15];
      u.vs2 = t.instr[24:20];
      u.eew = t.sew;
      if (t.op == VOP_WADD) u.eew = (t.sew == SEW8) ? SEW16 : SEW32;
      if (t.op == VOP_NSRL) u.eew = (t.sew == SEW32) ? SEW16 : SEW8;
      u.vs2_off0 = base + ((t.op == VOP_SLIDEDOWN) ? idx_add : 8'd0);
      u.vs2_off1 = u.vs2_off0 + 8'd1;
      u.wd_off0  = base + ((t.op == VOP_SLIDEUP) ? idx_add : 8'd0);
      u.wd_off1  = u.wd_off0 + 8'd1;
      for (int n = 0; n < 2; n++) begin
        idx = int'(base) + n;
        u.wen[n] = (t.op != VOP_ILLEGAL) && (idx < int'(t.vl)) &&
                   (t.instr[25] || (idx < 16 ? t.mask[idx % 16] : 1'b0));
      end
      u.imm  = (t.op == VOP_ADD) ? {{27{imm5[4]}}, imm5} : {27'd0, imm5};
      u.xs1  = t.xs1;
      u.last = int'(base) + 2 >= int'(t.vl);
      exp_q.push_back(u);
      base = base + 8'd2;
    end while (!u.last);
  endtask

  task automatic run_test(input test_t t);
    int          taken;
    logic [31:0] rnd;
    build_expected(t);
    taken = 0;
    @(posedge CLK);
    #1;
    instr      = t.instr;
    csr.vl     = t.vl;
    csr.vstart = t.vstart;
    csr.sew    = t.sew;
    xs1        = t.xs1;
    v0_mask    = t.mask;
    in_valid   = 1'b1;
    @(negedge CLK);
    check_value("in_ready", in_ready, 1);
    @(posedge CLK);
    #1 in_valid = 1'b0;
    while (exp_q.size() > 0) begin
      rnd = $random(seed);
      out_ready = t.stall ? rnd[0] : 1'b1;
      if (t.flush_after != 0 && taken == int'(t.flush_after)) begin
        out_ready = 1'b0;
        flush     = 1'b1;
        @(posedge CLK);
        #1 flush = 1'b0;
        @(negedge CLK);
        check_value("out_valid", out_valid, 0);
        check_value("in_ready", in_ready, 1);
        exp_q.delete();
      end else begin
        @(negedge CLK);
        // a pending non-final micro-op means the instruction is still stepping
        if (out_valid && !uop.last) check_value("in_ready", in_ready, 0);
        if (out_valid && out_ready) begin
          check_uop(uop, exp_q.pop_front());
          taken = taken + 1;
        end
        @(posedge CLK);
        #1;
      end
    end
    // nothing may follow the final micro-op
    @(negedge CLK);
    check_value("out_valid", out_valid, 0);
  endtask

  initial begin
    seed      = 32'h8f4e_8c91;
    errors    = 0;
    cycles    = 0;
    limit     = 0;
    nRST      = 1'b0;
    flush     = 1'b0;
    in_valid  = 1'b0;
    instr     = '0;
    csr       = '0;
    xs1       = '0;
    v0_mask   = '0;
    out_ready = 1'b0;

    tests[0]  = row(enc(6'b000000, 1, 2, 3, 3'b000, 1), VOP_ADD, 7, 0, SEW32, 0, 0, 0, 0);
    tests[1]  = row(enc(6'b000000, 0, 4, 5'b11101, 3'b011, 5), VOP_ADD, 9, 1, SEW8, 0,
                    16'ha5c3, 0, 0);
    tests[2]  = row(enc(6'b001111, 1, 6, 10, 3'b100, 7), VOP_SLIDEDOWN, 8, 0, SEW16, 3,
                    0, 0, 0);
    tests[3]  = row(enc(6'b001111, 1, 6, 5, 3'b011, 8), VOP_SLIDEDOWN, 6, 0, SEW8, 0,
                    0, 0, 0);
    tests[4]  = row(enc(6'b001110, 0, 9, 11, 3'b100, 12), VOP_SLIDEUP, 10, 2, SEW32, 2,
                    16'h0f0f, 0, 0);
    tests[5]  = row(enc(6'b001110, 1, 9, 4, 3'b011, 13), VOP_SLIDEUP, 5, 0, SEW16, 0,
                    0, 0, 0);
    // widening and narrowing at every sew, caps included
    tests[6]  = row(enc(6'b110001, 1, 2, 4, 3'b010, 6), VOP_WADD, 4, 0, SEW8, 0, 0, 0, 0);
    tests[7]  = row(enc(6'b110000, 1, 2, 4, 3'b010, 6), VOP_WADD, 4, 0, SEW16, 0, 0, 0, 0);
    tests[8]  = row(enc(6'b110001, 1, 2, 4, 3'b010, 6), VOP_WADD, 3, 0, SEW32, 0, 0, 0, 0);
    tests[9]  = row(enc(6'b101100, 1, 8, 3, 3'b011, 2), VOP_NSRL, 6, 0, SEW32, 0, 0, 0, 0);
    tests[10] = row(enc(6'b101100, 1, 8, 3, 3'b011, 2), VOP_NSRL, 4, 0, SEW16, 0, 0, 0, 0);
    tests[11] = row(enc(6'b101100, 1, 8, 3, 3'b011, 2), VOP_NSRL, 4, 0, SEW8, 0, 0, 0, 0);
    // random out_ready stalls
    tests[12] = row(enc(6'b000000, 0, 3, 7, 3'b100, 9), VOP_ADD, 16, 0, SEW8,
                    32'h1234_5678, 16'h6db7, 1, 0);
    tests[13] = row(enc(6'b001111, 1, 5, 1, 3'b100, 4), VOP_SLIDEDOWN, 13, 3, SEW16, 5,
                    0, 1, 0);
    // flush after two micro-ops, then a clean restart
    tests[14] = row(enc(6'b000000, 1, 2, 3, 3'b000, 1), VOP_ADD, 12, 0, SEW32, 0, 0, 0, 2);
    tests[15] = row(enc(6'b000000, 1, 7, 6, 3'b011, 3), VOP_ADD, 5, 0, SEW16, 0, 0, 0, 0);
    tests[16] = row(enc(6'b000010, 1, 2, 3, 3'b000, 1), VOP_ILLEGAL, 6, 0, SEW8, 0, 0, 0, 0);
    tests[17] = row(enc(6'b000000, 1, 2, 3, 3'b000, 1), VOP_ADD, 3, 5, SEW8, 0, 0, 0, 0);
    tests[18] = row(32'h0031_00b3, VOP_ILLEGAL, 2, 0, SEW32, 0, 0, 0, 0);

    // run limit sized from the table
    for (int i = 0; i < N_TESTS; i++) begin
      limit = limit + 4 * int'(tests[i].vl) + 20;
    end

    repeat (4) @(posedge CLK);
    #1 nRST = 1'b1;
    @(negedge CLK);
    check_value("in_ready", in_ready, 1);
    check_value("out_valid", out_valid, 0);

    for (int i = 0; i < N_TESTS; i++) begin
      run_test(tests[i]);
    end

    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/rv32v_decode_stage.sv
/* rv32v decode stage
   two-lane vector decode from instruction handshake to micro-op handshake */
`timescale 1ns/10ps
`default_nettype none

`include "vdec_consts.svh"

module rv32v_decode_stage (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              flush,
  input  logic              in_valid,
  output logic              in_ready,
  input  logic [31:0]       instr,
  input  vdec_pkg::vcsr_t   csr,
  input  logic [31:0]       xs1,
  input  logic [`VLENB-1:0] v0_mask,
  output logic              out_valid,
  input  logic              out_ready,
  output vdec_pkg::uop_t    uop
);
  import vdec_pkg::*;

  decode_ctrl_t ctrl;
  elem_pos_t    pos;
  uop_t         next_uop;
  logic         start;
  logic         step_valid;
  logic         step_ready;
  logic         last_taken;

  // counter loads vstart on the same edge that captures the instruction
  assign start = in_valid & in_ready;

  vector_control_unit vcu (
    .CLK        (CLK),
    .nRST       (nRST),
    .flush      (flush),
    .in_valid   (in_valid),
    .instr      (instr),
    .in_ready   (in_ready),
    .last_taken (last_taken),
    .busy       (),
    .ctrl       (ctrl)
  );

  element_counter elem_cnt (
    .CLK        (CLK),
    .nRST       (nRST),
    .flush      (flush),
    .start      (start),
    .csr        (csr),
    .step_ready (step_ready),
    .step_valid (step_valid),
    .pos        (pos),
    .last_taken (last_taken)
  );

  operand_offset_gen offset_gen (
    .ctrl    (ctrl),
    .pos     (pos),
    .csr     (csr),
    .xs1     (xs1),
    .v0_mask (v0_mask),
    .uop     (next_uop)
  );

  uop_pipe_reg out_reg (
    .CLK       (CLK),
    .nRST      (nRST),
    .flush     (flush),
    .in_valid  (step_valid),
    .in_ready  (step_ready),
    .uop_in    (next_uop),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .uop_out   (uop)
  );

endmodule

`default_nettype wire

// File: hw/uop_pipe_reg.sv
/* micro-op output register
   single-entry valid/ready stage toward execute, cleared by flush */
`timescale 1ns/10ps
`default_nettype none

module uop_pipe_reg (
  input  logic           CLK,
  input  logic           nRST,
  input  logic           flush,
  input  logic           in_valid,
  output logic           in_ready,
  input  vdec_pkg::uop_t uop_in,
  output logic           out_valid,
  input  logic           out_ready,
  output vdec_pkg::uop_t uop_out
);

  logic full;

  // take a new entry when empty or when the current one leaves this cycle
  assign in_ready  = ~full | out_ready;
  assign out_valid = full;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      full <= 1'b0;
    end else if (flush) begin
      full <= 1'b0;
    end else if (in_ready) begin
      full <= in_valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (in_valid && in_ready) begin
      uop_out <= uop_in;
    end
  end

endmodule

`default_nettype wire

// File: hw/operand_offset_gen.sv
/* operand offset generator
   builds the micro-op with lane offsets, effective width and masked enables */
`timescale 1ns/10ps
`default_nettype none

`include "vdec_consts.svh"

module operand_offset_gen (
  input  vdec_pkg::decode_ctrl_t ctrl,
  input  vdec_pkg::elem_pos_t    pos,
  input  vdec_pkg::vcsr_t        csr,
  input  logic [31:0]            xs1,
  input  logic [`VLENB-1:0]      v0_mask,
  output vdec_pkg::uop_t         uop
);
  import vdec_pkg::*;

  localparam int      IDX_W  = `OFFSET_W + 1;
  localparam int      MASK_W = $clog2(`VLENB);
  localparam offset_t ONE    = offset_t'(1);

  offset_t           rs1_off;
  offset_t           uimm_off;
  offset_t           vs2_add;
  offset_t           vd_add;
  offset_t           vs2_base;
  offset_t           vd_base;
  sew_t              eew;
  logic              legal;
  logic [IDX_W-1:0]  elem_idx;
  logic              mask_bit;
  logic [`LANES-1:0] wen;

  assign rs1_off  = xs1[`OFFSET_W-1:0];
  assign uimm_off = offset_t'(ctrl.imm5);

  always_comb begin
    case (ctrl.vs2_src)
      VS2_IDX_PLUS_RS1:  vs2_add = rs1_off;
      VS2_IDX_PLUS_UIMM: vs2_add = uimm_off;
      default:           vs2_add = '0;
    endcase
    case (ctrl.vd_src)
      VD_IDX_PLUS_RS1:  vd_add = rs1_off;
      VD_IDX_PLUS_UIMM: vd_add = uimm_off;
      default:          vd_add = '0;
    endcase
  end

  // lane 1 always sits one element above lane 0
  assign vs2_base = pos.base + vs2_add;
  assign vd_base  = pos.base + vd_add;

  // widen doubles sew, narrow halves it, both clamped to the legal range
  always_comb begin
    eew = csr.sew;
    if (ctrl.widen) begin
      case (csr.sew)
        SEW8:    eew = SEW16;
        default: eew = SEW32;
      endcase
    end else if (ctrl.narrow) begin
      case (csr.sew)
        SEW32:   eew = SEW16;
        default: eew = SEW8;
      endcase
    end
  end

  assign legal = ctrl.op != VOP_ILLEGAL;

  // elements at or past vl, or masked off by v0, are not written
  always_comb begin
    wen      = '0;
    elem_idx = '0;
    mask_bit = 1'b0;
    for (int n = 0; n < `LANES; n++) begin
      elem_idx = {1'b0, pos.base} + IDX_W'(n);
      mask_bit = (elem_idx < IDX_W'(`VLENB)) ? v0_mask[elem_idx[MASK_W-1:0]] : 1'b0;
      wen[n]   = legal && (elem_idx < {1'b0, csr.vl}) && (ctrl.vm || mask_bit);
    end
  end

  assign uop.op       = ctrl.op;
  assign uop.vd       = ctrl.vd;
  assign uop.vs1      = ctrl.vs1;
  assign uop.vs2      = ctrl.vs2;
  assign uop.eew      = eew;
  assign uop.vs2_off0 = vs2_base;
  assign uop.vs2_off1 = vs2_base + ONE;
  assign uop.wd_off0  = vd_base;
  assign uop.wd_off1  = vd_base + ONE;
  assign uop.wen      = wen;
  // only add treats imm5 as signed
  assign uop.imm      = (ctrl.op == VOP_ADD) ? {{27{ctrl.imm5[4]}}, ctrl.imm5}
                                             : {27'd0, ctrl.imm5};
  assign uop.xs1      = xs1;
  assign uop.last     = pos.last;

endmodule

`default_nettype wire

// File: hw/element_counter.sv
/* element counter
   steps the element pair from vstart toward vl and flags the final step */
`timescale 1ns/10ps
`default_nettype none

`include "vdec_consts.svh"

module element_counter (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                flush,
  input  logic                start,
  input  vdec_pkg::vcsr_t     csr,
  input  logic                step_ready,
  output logic                step_valid,
  output vdec_pkg::elem_pos_t pos,
  output logic                last_taken
);
  import vdec_pkg::*;

  localparam logic [`OFFSET_W:0] STEP = `LANES;

  offset_t            base;
  logic               active;
  logic               step;
  logic [`OFFSET_W:0] next_base;

  // one bit wider so the compare against vl cannot wrap
  assign next_base = {1'b0, base} + STEP;

  assign step_valid = active;
  assign step       = step_valid & step_ready;
  assign pos.base   = base;
  // also covers vl <= vstart, which gives a single step
  assign pos.last   = next_base >= {1'b0, csr.vl};
  assign last_taken = step & pos.last;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      active <= 1'b0;
      base   <= '0;
    end else if (flush) begin
      active <= 1'b0;
      base   <= '0;
    end else if (start) begin
      active <= 1'b1;
      base   <= csr.vstart;
    end else if (step) begin
      if (pos.last) begin
        active <= 1'b0;
      end
      base <= next_base[`OFFSET_W-1:0];
    end
  end

endmodule

`default_nettype wire

// File: hw/vector_control_unit.sv
/* vector control unit
   holds the accepted instruction and decodes it into control fields */
`timescale 1ns/10ps
`default_nettype none

module vector_control_unit (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   flush,
  input  logic                   in_valid,
  input  logic [31:0]            instr,
  output logic                   in_ready,
  input  logic                   last_taken,
  output logic                   busy,
  output vdec_pkg::decode_ctrl_t ctrl
);
  import vdec_pkg::*;

  localparam logic [6:0] OP_V       = 7'b1010111;
  localparam logic [2:0] F3_OPIVV   = 3'b000;
  localparam logic [2:0] F3_OPMVV   = 3'b010;
  localparam logic [2:0] F3_OPIVI   = 3'b011;
  localparam logic [2:0] F3_OPIVX   = 3'b100;
  localparam logic [5:0] F6_VADD    = 6'b000000;
  localparam logic [5:0] F6_SLIDEUP = 6'b001110;
  localparam logic [5:0] F6_SLIDEDN = 6'b001111;
  localparam logic [5:0] F6_VWADDU  = 6'b110000;
  localparam logic [5:0] F6_VWADD   = 6'b110001;
  localparam logic [5:0] F6_VNSRL   = 6'b101100;

  logic [31:0] instr_q;
  logic        accept;
  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [5:0]  funct6;

  // no new instruction while one is stepping or being flushed
  assign in_ready = ~busy & ~flush;
  assign accept   = in_valid & in_ready;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      busy <= 1'b0;
    end else if (flush) begin
      busy <= 1'b0;
    end else if (accept) begin
      busy <= 1'b1;
    end else if (last_taken) begin
      busy <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      instr_q <= instr;
    end
  end

  assign opcode = instr_q[6:0];
  assign funct3 = instr_q[14:12];
  assign funct6 = instr_q[31:26];

  always_comb begin
    ctrl.vd      = instr_q[11:7];
    ctrl.vs1     = instr_q[19:15];
    ctrl.vs2     = instr_q[24:20];
    ctrl.vm      = instr_q[25];
    ctrl.imm5    = instr_q[19:15];
    ctrl.op      = VOP_ILLEGAL;
    ctrl.vs2_src = VS2_NORMAL;
    ctrl.vd_src  = VD_NORMAL;
    ctrl.widen   = 1'b0;
    ctrl.narrow  = 1'b0;
    if (opcode == OP_V) begin
      case (funct6)
        F6_VADD: begin
          if (funct3 == F3_OPIVV || funct3 == F3_OPIVX || funct3 == F3_OPIVI) begin
            ctrl.op = VOP_ADD;
          end
        end
        // slide-down reads vs2 at an index offset from the element
        F6_SLIDEDN: begin
          if (funct3 == F3_OPIVX) begin
            ctrl.op      = VOP_SLIDEDOWN;
            ctrl.vs2_src = VS2_IDX_PLUS_RS1;
          end else if (funct3 == F3_OPIVI) begin
            ctrl.op      = VOP_SLIDEDOWN;
            ctrl.vs2_src = VS2_IDX_PLUS_UIMM;
          end
        end
        // slide-up writes vd at an index offset instead
        F6_SLIDEUP: begin
          if (funct3 == F3_OPIVX) begin
            ctrl.op     = VOP_SLIDEUP;
            ctrl.vd_src = VD_IDX_PLUS_RS1;
          end else if (funct3 == F3_OPIVI) begin
            ctrl.op     = VOP_SLIDEUP;
            ctrl.vd_src = VD_IDX_PLUS_UIMM;
          end
        end
        F6_VWADDU, F6_VWADD: begin
          if (funct3 == F3_OPMVV) begin
            ctrl.op    = VOP_WADD;
            ctrl.widen = 1'b1;
          end
        end
        F6_VNSRL: begin
          if (funct3 == F3_OPIVI) begin
            ctrl.op     = VOP_NSRL;
            ctrl.narrow = 1'b1;
          end
        end
        default: begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/vdec_pkg.sv
/* vector decode stage types
   enums and packed structs shared by the decode stage blocks */
`default_nettype none

`include "vdec_consts.svh"

package vdec_pkg;

  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_t;

  typedef enum logic [2:0] {
    VOP_ADD       = 3'd0,
    VOP_SLIDEDOWN = 3'd1,
    VOP_SLIDEUP   = 3'd2,
    VOP_WADD      = 3'd3,
    VOP_NSRL      = 3'd4,
    VOP_ILLEGAL   = 3'd7
  } vop_t;

  // how the vs2 element offset is formed
  typedef enum logic [1:0] {
    VS2_NORMAL        = 2'd0,
    VS2_IDX_PLUS_RS1  = 2'd1,
    VS2_IDX_PLUS_UIMM = 2'd2
  } vs2_src_t;

  // how the destination element offset is formed
  typedef enum logic [1:0] {
    VD_NORMAL        = 2'd0,
    VD_IDX_PLUS_RS1  = 2'd1,
    VD_IDX_PLUS_UIMM = 2'd2
  } vd_src_t;

  typedef logic [`OFFSET_W-1:0] offset_t;

  typedef struct packed {
    offset_t vl;
    offset_t vstart;
    sew_t    sew;
  } vcsr_t;

  typedef struct packed {
    vop_t       op;
    logic [4:0] vd;
    logic [4:0] vs1;
    logic [4:0] vs2;
    vs2_src_t   vs2_src;
    vd_src_t    vd_src;
    logic       vm;
    logic [4:0] imm5;
    logic       widen;
    logic       narrow;
  } decode_ctrl_t;

  typedef struct packed {
    offset_t base;
    logic    last;
  } elem_pos_t;

  typedef struct packed {
    vop_t              op;
    logic [4:0]        vd;
    logic [4:0]        vs1;
    logic [4:0]        vs2;
    sew_t              eew;
    offset_t           vs2_off0;
    offset_t           vs2_off1;
    offset_t           wd_off0;
    offset_t           wd_off1;
    logic [`LANES-1:0] wen;
    logic [31:0]       imm;
    logic [31:0]       xs1;
    logic              last;
  } uop_t;

endpackage

`default_nettype wire

// File: hw/vdec_consts.svh
/* vector decode constants
   register length, elements per cycle and element offset width */
`ifndef VDEC_CONSTS_SVH
`define VDEC_CONSTS_SVH

// vector register length in bits
`define VLEN 128

// register length in bytes
// also the number of v0 mask bits seen by the stage
`define VLENB (`VLEN / 8)

// elements handled per micro-op, one per lane
`define LANES 2

// width of an element offset
`define OFFSET_W 8

`endif
